// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module fpuCore_tb -o simv

run: build
	@out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q '^=== PASS ===$$'

lint:
	verilator --lint-only --timing --assert -f project.f --top-module fpuCore_tb

clean:
	rm -rf obj_dir

// ==== hdl/fpRegArb.sv ====
`default_nettype none

module fpRegArb import fpuPkg::*; (
	input  logic		clock,
	input  logic		rstN,
	fpRegIf.arbiter		host,			// host strobes, top priority
	fpRegIf.arbiter		exec,			// compare executor
	fpRegIf.requester	mem,			// toward storage
	output logic		hostRdValid		// host read data on rdata
);

	logic	hostSel;
	logic	selWe;
	fpIdx_t	selIdx;
	fpReg_t	selWdata;
	logic	hostRdLast;		// last read taken belonged to host

	assign hostSel = host.req;		// host always wins

	assign host.gnt = host.req;
	assign exec.gnt = exec.req && !host.req;	// only on idle host cycles

	always_comb begin
		if (hostSel) begin
			selWe = host.we;
			selIdx = host.idx;
			selWdata = host.wdata;
		end else begin
			selWe = exec.we;
			selIdx = exec.idx;
			selWdata = exec.wdata;
		end
	end

	assign mem.req = host.req || exec.req;
	assign mem.we = selWe;
	assign mem.idx = selIdx;
	assign mem.wdata = selWdata;

	// read data shared, each side knows when it is theirs
	assign host.rdata = mem.rdata;
	assign exec.rdata = mem.rdata;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			hostRdLast <= 1'b0;
		end else begin
			hostRdLast <= mem.req && mem.gnt && !mem.we && hostSel;
		end
	end

	assign hostRdValid = hostRdLast;

endmodule

`default_nettype wire

// ==== hdl/fpRegFile.sv ====
`include "fpuDefs.svh"

`default_nettype none

module fpRegFile import fpuPkg::*; (
	input  logic		clock,
	input  logic		rstN,
	fpRegIf.storage		port		// already arbitrated access
);

	fpReg_t	regArr [`FPU_NREGS];		// the FPRs

	// storage, cleared so reads after reset return zero
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `FPU_NREGS; i++) begin
				regArr[i] <= '0;
			end
		end else if (port.req && port.we) begin
			regArr[port.idx] <= port.wdata;
		end
	end

	// one-cycle read, holds until the next read
	always_ff @(posedge clock) begin
		if (port.req && !port.we) begin
			port.rdata <= regArr[port.idx];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fpRegIf.sv ====
`default_nettype none

// one access port into the FPR storage
interface fpRegIf import fpuPkg::*; ();

	logic	req;		// access request
	logic	we;			// write when set, else read
	fpIdx_t	idx;		// register number
	fpReg_t	wdata;		// write payload
	logic	gnt;		// access taken this edge
	fpReg_t	rdata;		// valid the cycle after a read

	modport requester (
		output	req, we, idx, wdata,
		input	gnt, rdata
	);

	modport arbiter (
		input	req, we, idx, wdata,
		output	gnt, rdata
	);

	modport storage (
		input	req, we, idx, wdata,
		output	rdata
	);

endinterface

`default_nettype wire

// ==== hdl/fpuCmp.sv ====
`default_nettype none

module fpuCmp import fpuPkg::*; (
	input  fpCmpOp_e	opCmd,		// compare sub-op
	input  fpReg_t		regValRs,	// Rs value
	input  fpReg_t		regValRt,	// Rt value
	output logic		regOutSrT	// status bit
);

	logic			sgnRs;
	logic			sgnRt;
	logic [10:0]	expRs;
	logic [10:0]	expRt;
	logic [51:0]	fraRs;
	logic [51:0]	fraRt;

	logic			rsIsNaN;
	logic			rtIsNaN;

	logic			expEq;
	logic			expGt;

	// fraction split in three chunks, extra bit catches the borrow
	logic [18:0]	fraSub0;
	logic [18:0]	fraSub1;
	logic [16:0]	fraSub2;
	logic			fraEq0;
	logic			fraEq1;
	logic			fraEq2;
	logic			fraGt0;
	logic			fraGt1;
	logic			fraGt2;
	logic			fraEq;
	logic			fraGt;

	logic			magEq;
	logic			magGt;
	logic			cmpEq;
	logic			cmpGt;

	assign sgnRs = regValRs[63];
	assign sgnRt = regValRt[63];
	assign expRs = regValRs[62:52];
	assign expRt = regValRt[62:52];
	assign fraRs = regValRs[51:0];
	assign fraRt = regValRt[51:0];

	always_comb begin
		rsIsNaN = (expRs == 11'h7FF) && (fraRs != '0);
		rtIsNaN = (expRt == 11'h7FF) && (fraRt != '0);

		expEq = (expRs == expRt);
		expGt = (expRs > expRt);

		fraSub0 = {1'b0, fraRt[51:34]} - {1'b0, fraRs[51:34]};
		fraSub1 = {1'b0, fraRt[33:16]} - {1'b0, fraRs[33:16]};
		fraSub2 = {1'b0, fraRt[15:0]} - {1'b0, fraRs[15:0]};
		fraEq0 = (fraSub0 == '0);
		fraEq1 = (fraSub1 == '0);
		fraEq2 = (fraSub2 == '0);
		fraGt0 = fraSub0[18];		// borrow means Rs chunk larger
		fraGt1 = fraSub1[18];
		fraGt2 = fraSub2[16];

		fraEq = fraEq0 && fraEq1 && fraEq2;
		fraGt = fraGt0 ||
			(fraGt1 && fraEq0) ||
			(fraGt2 && fraEq0 && fraEq1);

		// magnitude order, exponent before fraction
		magEq = expEq && fraEq;
		magGt = expGt || (expEq && fraGt);

		case ({sgnRs, sgnRt})
			2'b00: begin
				cmpEq = magEq;
				cmpGt = magGt;
			end
			2'b01: begin
				cmpEq = 1'b0;
				cmpGt = 1'b1;		// positive beats negative
			end
			2'b10: begin
				cmpEq = 1'b0;
				cmpGt = 1'b0;
			end
			default: begin
				cmpEq = magEq;
				cmpGt = !magGt && !magEq;	// both negative, order flips
			end
		endcase

		if (rsIsNaN || rtIsNaN) begin	// unordered
			cmpEq = 1'b0;
			cmpGt = 1'b0;
		end

		case (opCmd)
			CMPEQ:		regOutSrT = cmpEq;
			CMPGT:		regOutSrT = cmpGt;
			CMPNE:		regOutSrT = !cmpEq;
			CMPGE:		regOutSrT = cmpGt || cmpEq;
			default:	regOutSrT = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/fpuCore.sv ====
`default_nettype none

module fpuCore import fpuPkg::*; (
	input  logic		clock,
	input  logic		rstN,

	// host register access
	input  logic		hostWrEn,
	input  logic		hostRdEn,
	input  fpIdx_t		hostIdx,
	input  fpReg_t		hostWrData,
	output fpReg_t		hostRdData,
	output logic		hostRdValid,

	// compare command
	input  logic		cmdValid,
	input  fpCmpOp_e	cmdOp,
	input  fpIdx_t		cmdRs,
	input  fpIdx_t		cmdRt,
	output logic		busy,
	output logic		srT,
	output logic		srTValid
);

	fpRegIf hostBus ();
	fpRegIf execBus ();
	fpRegIf memBus ();

	// host strobes onto the host port
	assign hostBus.req = hostWrEn || hostRdEn;
	assign hostBus.we = hostWrEn;			// write wins over same-cycle read
	assign hostBus.idx = hostIdx;
	assign hostBus.wdata = hostWrData;
	assign hostRdData = hostBus.rdata;

	assign memBus.gnt = memBus.req;			// storage takes every access

	fpRegArb fpRegArb_i (
		.clock			(clock),
		.rstN			(rstN),
		.host			(hostBus),
		.exec			(execBus),
		.mem			(memBus),
		.hostRdValid	(hostRdValid)
	);

	fpRegFile fpRegFile_i (
		.clock	(clock),
		.rstN	(rstN),
		.port	(memBus)
	);

	fpuExec fpuExec_i (
		.clock		(clock),
		.rstN		(rstN),
		.cmdValid	(cmdValid),
		.cmdOp		(cmdOp),
		.cmdRs		(cmdRs),
		.cmdRt		(cmdRt),
		.busy		(busy),
		.srT		(srT),
		.srTValid	(srTValid),
		.mem		(execBus)
	);

endmodule

`default_nettype wire

// ==== hdl/fpuDefs.svh ====
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

`default_nettype none

// floating-point register file geometry
`define FPU_NREGS	16		// number of FPRs
`define FPU_IDXW	4		// bits to address one FPR

`default_nettype wire

`endif

// ==== hdl/fpuExec.sv ====
`default_nettype none

module fpuExec import fpuPkg::*; (
	input  logic		clock,
	input  logic		rstN,
	input  logic		cmdValid,		// start a compare
	input  fpCmpOp_e	cmdOp,
	input  fpIdx_t		cmdRs,
	input  fpIdx_t		cmdRt,
	output logic		busy,
	output logic		srT,			// compare result
	output logic		srTValid,		// one-cycle result pulse
	fpRegIf.requester	mem
);

	execState_e	state;
	fpCmpOp_e	opLatch;		// held while busy
	fpIdx_t		idxRs;
	fpIdx_t		idxRt;
	fpReg_t		valRs;
	fpReg_t		valRt;
	logic		rsPend;			// Rs on rdata this cycle
	logic		rtPend;			// Rt on rdata this cycle
	logic		cmpSrT;

	fpuCmp fpuCmp_i (
		.opCmd		(opLatch),
		.regValRs	(valRs),
		.regValRt	(valRt),
		.regOutSrT	(cmpSrT)
	);

	// read port, Rs first then Rt
	assign mem.req = (state == READ_RS) || (state == READ_RT);
	assign mem.we = 1'b0;
	assign mem.idx = (state == READ_RT) ? idxRt : idxRs;
	assign mem.wdata = '0;

	assign busy = (state != IDLE);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			rsPend <= 1'b0;
			rtPend <= 1'b0;
			srT <= 1'b0;
			srTValid <= 1'b0;
		end else begin
			rsPend <= (state == READ_RS) && mem.gnt;
			rtPend <= (state == READ_RT) && mem.gnt;
			srTValid <= 1'b0;
			case (state)
				IDLE: begin
					if (cmdValid)
						state <= READ_RS;
				end
				READ_RS: begin
					if (mem.gnt)
						state <= READ_RT;		// Rs lands while Rt is asked for
				end
				READ_RT: begin
					if (mem.gnt)
						state <= COMPARE;
				end
				default: begin
					// first COMPARE cycle only captures Rt
					if (!rtPend) begin
						srT <= cmpSrT;
						srTValid <= 1'b1;
						state <= IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && cmdValid) begin
			opLatch <= cmdOp;
			idxRs <= cmdRs;
			idxRt <= cmdRt;
		end
		if (rsPend)
			valRs <= mem.rdata;
		if (rtPend)
			valRt <= mem.rdata;
	end

endmodule

`default_nettype wire

// ==== hdl/fpuPkg.sv ====
`include "fpuDefs.svh"

`default_nettype none

package fpuPkg;

	typedef logic [63:0] fpReg_t;				// raw IEEE double
	typedef logic [`FPU_IDXW-1:0] fpIdx_t;		// FPR number

	// compare sub-ops, srT gets the result
	typedef enum logic [1:0] {
		CMPEQ	= 2'd0,
		CMPGT	= 2'd1,
		CMPNE	= 2'd2,
		CMPGE	= 2'd3
	} fpCmpOp_e;

	typedef enum logic [1:0] {
		IDLE	= 2'd0,		// waiting for a command
		READ_RS	= 2'd1,		// fetching first operand
		READ_RT	= 2'd2,		// fetching second operand
		COMPARE	= 2'd3		// last capture, then result
	} execState_e;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/fpuPkg.sv
hdl/fpRegIf.sv
hdl/fpuCmp.sv
hdl/fpRegFile.sv
hdl/fpRegArb.sv
hdl/fpuExec.sv
hdl/fpuCore.sv
sim/fpuCore_sva.sv
sim/fpuCore_tb.sv

// ==== sim/fpuCore_sva.sv ====
`default_nettype none

module fpuCore_sva import fpuPkg::*; (
	input wire logic	clock,
	input wire logic	rstN,
	input wire logic	hostWrEn,
	input wire logic	hostRdEn,
	input wire logic	hostRdValid,
	input wire logic	busy,
	input wire logic	srTValid
);

	timeunit 1ns;
	timeprecision 100ps;

	int assertFails = 0;		// read by the testbench at the end

	srtSinglePulse: assert property (@(posedge clock) disable iff (!rstN)
		srTValid |=> !srTValid)
		else begin
			$error("srTValid high for two cycles");
			assertFails++;
		end

	hostRdOneCycle: assert property (@(posedge clock) disable iff (!rstN)
		(hostRdEn && !hostWrEn) |=> hostRdValid)
		else begin
			$error("hostRdValid missing after hostRdEn");
			assertFails++;
		end

	hostRdNoExtra: assert property (@(posedge clock) disable iff (!rstN)
		hostRdValid |-> $past(hostRdEn && !hostWrEn))
		else begin
			$error("hostRdValid without a host read");
			assertFails++;
		end

	busyDropsAtDone: assert property (@(posedge clock) disable iff (!rstN)
		srTValid |-> !busy)
		else begin
			$error("busy still high with srTValid");
			assertFails++;
		end

	// async reset, outputs quiet the whole time
	quietInReset: assert property (@(posedge clock)
		!rstN |-> (!busy && !srTValid && !hostRdValid))
		else begin
			$error("outputs active during reset");
			assertFails++;
		end

endmodule

bind fpuCore fpuCore_sva fpuCore_sva_i (
	.clock			(clock),
	.rstN			(rstN),
	.hostWrEn		(hostWrEn),
	.hostRdEn		(hostRdEn),
	.hostRdValid	(hostRdValid),
	.busy			(busy),
	.srTValid		(srTValid)
);

`default_nettype wire

// ==== sim/fpuCore_tb.sv ====
`default_nettype none

module fpuCore_tb import fpuPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAND_PAIRS = 200;
	localparam int WATCHDOG_NS = (RAND_PAIRS * 10 + 500) * 8;	// ~10 cycles per pair plus rest

	logic		clock;
	logic		rstN;
	logic		hostWrEn;
	logic		hostRdEn;
	fpIdx_t		hostIdx;
	fpReg_t		hostWrData;
	fpReg_t		hostRdData;
	logic		hostRdValid;
	logic		cmdValid;
	fpCmpOp_e	cmdOp;
	fpIdx_t		cmdRs;
	fpIdx_t		cmdRt;
	logic		busy;
	logic		srT;
	logic		srTValid;

	logic [31:0]	lcgState = 32'hae729918;
	int				errCount = 0;
	int				testsRun = 0;
	int				testsFailed = 0;
	int				pulseCount = 0;		// srTValid pulses seen
	fpReg_t			shadow [16];		// expected register contents

	fpuCore fpuCore_i (.*);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		if (srTValid)
			pulseCount++;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic fpReg_t randReg();
		return {lcgNext(), lcgNext()};
	endfunction

	// IEEE ordering with negatives mirrored and NaN unordered
	function automatic logic refCompare(fpCmpOp_e op, fpReg_t a, fpReg_t b);
		logic nan;
		logic eq;
		logic gt;
		nan = (a[62:52] == 11'h7FF && a[51:0] != '0) ||
			(b[62:52] == 11'h7FF && b[51:0] != '0);
		eq = !nan && (a == b);
		if (nan)
			gt = 1'b0;
		else if (a[63] != b[63])
			gt = !a[63];
		else if (a[63])
			gt = a[62:0] < b[62:0];
		else
			gt = a[62:0] > b[62:0];
		case (op)
			CMPEQ:		return eq;
			CMPGT:		return gt;
			CMPNE:		return !eq;
			default:	return gt || eq;
		endcase
	endfunction

	task automatic checkReg(string name, fpReg_t exp, fpReg_t act);
		if (exp !== act) begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkBit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			errCount++;
		end
	endtask

	task automatic checkLatency(int expCycles, int cycles);
		if (srTValid && cycles != expCycles) begin
			$display("compare result came after %0d cycles instead of %0d at %0t ns",
				cycles, expCycles, $time);
			errCount++;
		end
	endtask

	// all drive tasks start and end on a falling edge
	task automatic hostWrite(fpIdx_t idx, fpReg_t data);
		hostWrEn = 1'b1;
		hostIdx = idx;
		hostWrData = data;
		@(negedge clock);
		hostWrEn = 1'b0;
		shadow[idx] = data;
	endtask

	task automatic hostRead(fpIdx_t idx);
		hostRdEn = 1'b1;
		hostIdx = idx;
		@(negedge clock);
		hostRdEn = 1'b0;
		checkBit("hostRdValid", 1'b1, hostRdValid);		// exactly one cycle later
		checkReg("hostRdData", shadow[idx], hostRdData);
	endtask

	task automatic issueCmd(fpCmpOp_e op, fpIdx_t rs, fpIdx_t rt);
		cmdValid = 1'b1;
		cmdOp = op;
		cmdRs = rs;
		cmdRt = rt;
		@(negedge clock);
		cmdValid = 1'b0;
	endtask

	task automatic waitResult(int maxCycles, output int cycles);
		cycles = 0;
		while (!srTValid && cycles < maxCycles) begin
			@(negedge clock);
			cycles++;
		end
		if (!srTValid) begin
			$display("compare result never arrived within %0d cycles at %0t ns",
				maxCycles, $time);
			errCount++;
		end
	endtask

	task automatic compareRegs(fpCmpOp_e op, fpIdx_t rs, fpIdx_t rt, logic exp);
		int cycles;
		issueCmd(op, rs, rt);
		checkBit("busy", 1'b1, busy);
		waitResult(20, cycles);
		checkLatency(4, cycles);
		checkBit("srT", exp, srT);
	endtask

	task automatic finishTest(string name, int errBefore);
		testsRun++;
		if (errCount == errBefore) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: failed", name);
		end
	endtask

	task automatic testReset();
		int errBefore;
		errBefore = errCount;
		checkBit("busy", 1'b0, busy);
		checkBit("srTValid", 1'b0, srTValid);
		checkBit("hostRdValid", 1'b0, hostRdValid);
		for (int i = 0; i < 16; i++) begin
			shadow[i] = '0;
			hostRead(fpIdx_t'(i));
		end
		finishTest("reset", errBefore);
	endtask

	task automatic testHostRw();
		int errBefore;
		fpReg_t wrData;
		errBefore = errCount;
		for (int i = 0; i < 16; i++)
			hostWrite(fpIdx_t'(i), randReg());
		for (int i = 0; i < 16; i++)
			hostRead(fpIdx_t'(i));
		wrData = randReg();
		hostWrEn = 1'b1;
		hostRdEn = 1'b1;
		hostIdx = 4'd0;
		hostWrData = wrData;
		@(negedge clock);
		hostWrEn = 1'b0;
		hostRdEn = 1'b0;
		shadow[0] = wrData;
		checkBit("hostRdValid", 1'b0, hostRdValid);		// the write takes the slot
		hostRead(4'd0);
		finishTest("host write/read", errBefore);
	endtask

	task automatic testDirected();
		int errBefore;
		fpReg_t caseRs [12];
		fpReg_t caseRt [12];
		errBefore = errCount;
		caseRs = '{64'h3FF0000000000000, 64'h3FF0000000000000, 64'hBFF0000000000000,
			64'h4000000000000000, 64'h3FF8000000000000, 64'h3FF0000200000000,
			64'h3FF0000000000001, 64'hC000000000000000, 64'h7FF8000000000000,
			64'h3FF0000000000000, 64'h0000000000000000, 64'hBFF0000000000000};
		caseRt = '{64'h3FF0000000000000, 64'hBFF0000000000000, 64'h3FF0000000000000,
			64'h3FF0000000000000, 64'h3FF0000000000000, 64'h3FF0000000000000,
			64'h3FF0000000000000, 64'hBFF0000000000000, 64'h3FF0000000000000,
			64'hFFF0000000000001, 64'h8000000000000000, 64'hBFF0000000000000};
		for (int c = 0; c < 12; c++) begin
			hostWrite(4'd1, caseRs[c]);
			hostWrite(4'd2, caseRt[c]);
			for (int op = 0; op < 4; op++)
				compareRegs(fpCmpOp_e'(op[1:0]), 4'd1, 4'd2,
					refCompare(fpCmpOp_e'(op[1:0]), caseRs[c], caseRt[c]));
		end
		finishTest("directed compares", errBefore);
	endtask

	task automatic testRandom();
		int errBefore;
		fpReg_t a;
		fpReg_t b;
		logic [31:0] r;
		fpCmpOp_e op;
		errBefore = errCount;
		for (int n = 0; n < RAND_PAIRS; n++) begin
			a = randReg();
			b = randReg();
			r = lcgNext();
			op = fpCmpOp_e'(r[7:6]);
			if (r[0])
				b[63:52] = a[63:52];		// same sign and exponent
			if (r[0] && r[1])
				b[51:34] = a[51:34];
			if (r[0] && r[1] && r[2])
				b[33:16] = a[33:16];
			hostWrite(4'd3, a);
			hostWrite(4'd4, b);
			if (r[5:3] == 3'd0)
				compareRegs(op, 4'd3, 4'd3, refCompare(op, a, a));
			else
				compareRegs(op, 4'd3, 4'd4, refCompare(op, a, b));
		end
		finishTest("random compares", errBefore);
	endtask

	task automatic testContention();
		int errBefore;
		int pulses;
		int cycles;
		errBefore = errCount;
		hostWrite(4'd5, randReg());
		hostWrite(4'd6, randReg());
		hostWrite(4'd8, randReg());
		pulses = pulseCount;
		issueCmd(CMPGE, 4'd5, 4'd6);
		repeat (10) begin		// executor starved the whole time
			hostWrite(4'd7, randReg());
			hostRead(4'd8);
		end
		checkBit("busy", 1'b1, busy);
		waitResult(20, cycles);
		checkLatency(4, cycles);		// full fetch still ahead once the host stops
		checkBit("srT", refCompare(CMPGE, shadow[5], shadow[6]), srT);
		@(negedge clock);
		if (pulseCount - pulses != 1) begin
			$display("saw %0d result pulses instead of one at %0t ns",
				pulseCount - pulses, $time);
			errCount++;
		end
		finishTest("contention", errBefore);
	endtask

	task automatic testIgnored();
		int errBefore;
		int pulses;
		int cycles;
		errBefore = errCount;
		hostWrite(4'd9, randReg());
		hostWrite(4'd10, randReg());
		pulses = pulseCount;
		issueCmd(CMPGT, 4'd9, 4'd10);
		issueCmd(CMPEQ, 4'd10, 4'd9);		// lands while busy
		waitResult(20, cycles);
		checkLatency(3, cycles);		// one of the four cycles went to the second command
		checkBit("srT", refCompare(CMPGT, shadow[9], shadow[10]), srT);
		repeat (8) @(negedge clock);
		checkBit("busy", 1'b0, busy);
		if (pulseCount - pulses != 1) begin
			$display("saw %0d result pulses instead of one at %0t ns",
				pulseCount - pulses, $time);
			errCount++;
		end
		finishTest("ignored command", errBefore);
	endtask

	initial begin
		clock = 1'b0;
		rstN = 1'b0;
		hostWrEn = 1'b0;
		hostRdEn = 1'b0;
		hostIdx = '0;
		hostWrData = '0;
		cmdValid = 1'b0;
		cmdOp = CMPEQ;
		cmdRs = '0;
		cmdRt = '0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		testReset();
		testHostRw();
		testDirected();
		testRandom();
		testContention();
		testIgnored();
		$display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, errCount, fpuCore_i.fpuCore_sva_i.assertFails);
		if (errCount == 0 && testsFailed == 0 && fpuCore_i.fpuCore_sva_i.assertFails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire
